//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= tb_rv64_core
FLIST     ?= flist.f
PASS_MSG  := Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

test: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- flist.f
logic/rv_pkg.sv
logic/dec_if.sv
logic/decoder.sv
logic/alu.sv
logic/regfile.sv
logic/lsu.sv
logic/rv64_core.sv
test/tb_clkgen.sv
test/tb_rv64_core.sv

//--- logic/alu.sv
// ****************************
// 64-bit alu with word shifts and the branch compare
// ****************************
`timescale 1ns/1ps
`default_nettype none

module alu import rv_pkg::*; (
  input  alu_op_e         op,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output logic [xlen-1:0] result,
  output logic            taken
);

  logic        eq;
  logic        lt_s;
  logic        lt_u;
  logic [31:0] word_res;

  assign eq   = (a == b);
  assign lt_s = ($signed(a) < $signed(b));
  assign lt_u = (a < b);

  // w ops on the low half, shamt is 5 bits
  always_comb begin
    case (op)
      alu_addw: word_res = a[31:0] + b[31:0];
      alu_sllw: word_res = a[31:0] << b[4:0];
      alu_srlw: word_res = a[31:0] >> b[4:0];
      alu_sraw: word_res = $signed(a[31:0]) >>> b[4:0];
      default:  word_res = '0;
    endcase
  end

  always_comb begin
    case (op)
      alu_add:      result = a + b;
      alu_sub:      result = a - b;
      alu_lt:       result = {{(xlen-1){1'b0}}, lt_s};
      alu_ltu:      result = {{(xlen-1){1'b0}}, lt_u};
      alu_and:      result = a & b;
      alu_or:       result = a | b;
      alu_xor:      result = a ^ b;
      alu_sll:      result = a << b[5:0];
      alu_srl:      result = a >> b[5:0];
      alu_sra:      result = $signed(a) >>> b[5:0];
      alu_pass_imm: result = b;
      alu_eq:       result = {{(xlen-1){1'b0}}, eq};
      alu_ne:       result = {{(xlen-1){1'b0}}, ~eq};
      alu_ge:       result = {{(xlen-1){1'b0}}, ~lt_s};
      alu_geu:      result = {{(xlen-1){1'b0}}, ~lt_u};
      alu_addw,
      alu_sllw,
      alu_srlw,
      alu_sraw:     result = {{32{word_res[31]}}, word_res};  // sign-extend
      default:      result = '0;
    endcase
  end

  // branch condition
  always_comb begin
    case (op)
      alu_eq:  taken = eq;
      alu_ne:  taken = ~eq;
      alu_lt:  taken = lt_s;
      alu_ge:  taken = ~lt_s;
      alu_ltu: taken = lt_u;
      alu_geu: taken = ~lt_u;
      default: taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/dec_if.sv
// ****************************
// decoded fields and control, decoder to core datapath
// ****************************
`timescale 1ns/1ps
`default_nettype none

interface dec_if import rv_pkg::*; ();
  logic [reg_id_w-1:0] rd;
  logic [reg_id_w-1:0] rs1;
  logic [reg_id_w-1:0] rs2;
  logic [xlen-1:0]     imm;
  logic                need_imm;  // operand b from imm, not rs2
  alu_op_e             alu_op;
  logic                is_auipc;
  logic                is_jal;
  logic                is_jalr;
  logic                is_branch;
  logic                is_load;
  logic                is_store;
  logic                is_ebreak;
  logic                is_unsigned;  // zero-extending load
  logic                illegal;
  logic                reg_wen;
  width_e              mem_width;

  modport dec (output rd, rs1, rs2, imm, need_imm, alu_op, is_auipc, is_jal, is_jalr,
               is_branch, is_load, is_store, is_ebreak, is_unsigned, illegal,
               reg_wen, mem_width);
  modport dp (input rd, rs1, rs2, imm, need_imm, alu_op, is_auipc, is_jal, is_jalr,
              is_branch, is_load, is_store, is_ebreak, is_unsigned, illegal,
              reg_wen, mem_width);
endinterface

`default_nettype wire

//--- logic/decoder.sv
// ****************************
// combinational rv64i decoder, one term per supported instruction
// anything outside the recognised set raises illegal
// ****************************
`timescale 1ns/1ps
`default_nettype none

module decoder import rv_pkg::*; (
  input  logic [inst_w-1:0] inst,
  dec_if.dec                dec
);

  // ****************************
  // field matches
  // ****************************
  wire opc_imm    = (inst[6:0] == op_imm);
  wire opc_imm_32 = (inst[6:0] == op_imm_32);
  wire opc_op     = (inst[6:0] == op_op);
  wire opc_32     = (inst[6:0] == op_32);
  wire opc_lui    = (inst[6:0] == op_lui);
  wire opc_auipc  = (inst[6:0] == op_auipc);
  wire opc_jal    = (inst[6:0] == op_jal);
  wire opc_jalr   = (inst[6:0] == op_jalr);
  wire opc_branch = (inst[6:0] == op_branch);
  wire opc_load   = (inst[6:0] == op_load);
  wire opc_store  = (inst[6:0] == op_store);
  wire opc_system = (inst[6:0] == op_system);

  wire [7:0] f3 = 8'b1 << inst[14:12];  // one-hot funct3
  wire f7_zero  = (inst[31:25] == 7'b0000000);
  wire f7_alt   = (inst[31:25] == 7'b0100000);
  wire sh6_zero = (inst[31:26] == 6'b000000);  // 64-bit shamt keeps bit 25
  wire sh6_alt  = (inst[31:26] == 6'b010000);

  // 2.4 integer computational, register-immediate
  wire addi  = opc_imm & f3[0];
  wire slti  = opc_imm & f3[2];
  wire sltiu = opc_imm & f3[3];
  wire xori  = opc_imm & f3[4];
  wire ori   = opc_imm & f3[6];
  wire andi  = opc_imm & f3[7];
  wire slli  = opc_imm & f3[1] & sh6_zero;
  wire srli  = opc_imm & f3[5] & sh6_zero;
  wire srai  = opc_imm & f3[5] & sh6_alt;

  // register-register
  wire add      = opc_op & f3[0] & f7_zero;
  wire sub      = opc_op & f3[0] & f7_alt;
  wire sll      = opc_op & f3[1] & f7_zero;
  wire slt      = opc_op & f3[2] & f7_zero;
  wire sltu     = opc_op & f3[3] & f7_zero;
  wire xor_inst = opc_op & f3[4] & f7_zero;
  wire srl      = opc_op & f3[5] & f7_zero;
  wire sra      = opc_op & f3[5] & f7_alt;
  wire or_inst  = opc_op & f3[6] & f7_zero;
  wire and_inst = opc_op & f3[7] & f7_zero;

  // 2.5 control transfer
  wire jal  = opc_jal;
  wire jalr = opc_jalr & f3[0];
  wire beq  = opc_branch & f3[0];
  wire bne  = opc_branch & f3[1];
  wire blt  = opc_branch & f3[4];
  wire bge  = opc_branch & f3[5];
  wire bltu = opc_branch & f3[6];
  wire bgeu = opc_branch & f3[7];

  // 2.6 loads and stores
  wire lb  = opc_load & f3[0];
  wire lh  = opc_load & f3[1];
  wire lw  = opc_load & f3[2];
  wire ld  = opc_load & f3[3];
  wire lbu = opc_load & f3[4];
  wire lhu = opc_load & f3[5];
  wire lwu = opc_load & f3[6];
  wire sb  = opc_store & f3[0];
  wire sh  = opc_store & f3[1];
  wire sw  = opc_store & f3[2];
  wire sd  = opc_store & f3[3];

  // 2.8 breakpoint
  wire ebreak = opc_system & f3[0] & (inst[31:20] == 12'h001);

  // rv64i word forms, no addw/subw
  wire addiw = opc_imm_32 & f3[0];
  wire slliw = opc_imm_32 & f3[1] & f7_zero;
  wire srliw = opc_imm_32 & f3[5] & f7_zero;
  wire sraiw = opc_imm_32 & f3[5] & f7_alt;
  wire sllw  = opc_32 & f3[1] & f7_zero;
  wire srlw  = opc_32 & f3[5] & f7_zero;
  wire sraw  = opc_32 & f3[5] & f7_alt;

  wire alu_imm_grp = addi | slti | sltiu | xori | ori | andi | slli | srli | srai;
  wire alu_reg_grp = add | sub | sll | slt | sltu | xor_inst | srl | sra | or_inst | and_inst;
  wire word_grp    = addiw | slliw | srliw | sraiw | sllw | srlw | sraw;
  wire branch_grp  = beq | bne | blt | bge | bltu | bgeu;
  wire load_grp    = lb | lh | lw | ld | lbu | lhu | lwu;
  wire store_grp   = sb | sh | sw | sd;

  // ****************************
  // immediate
  // ****************************
  wire fmt_i = opc_imm | opc_imm_32 | opc_load | opc_jalr;
  wire fmt_s = opc_store;
  wire fmt_b = opc_branch;
  wire fmt_u = opc_lui | opc_auipc;
  wire fmt_j = opc_jal;

  imm_fmt_e imm_fmt;

  always_comb begin
    if (fmt_i)      imm_fmt = imm_i;
    else if (fmt_s) imm_fmt = imm_s;
    else if (fmt_b) imm_fmt = imm_b;
    else if (fmt_u) imm_fmt = imm_u;
    else if (fmt_j) imm_fmt = imm_j;
    else            imm_fmt = imm_none;
  end

  always_comb begin
    case (imm_fmt)
      imm_i:   dec.imm = {{52{inst[31]}}, inst[31:20]};
      imm_s:   dec.imm = {{52{inst[31]}}, inst[31:25], inst[11:7]};
      imm_b:   dec.imm = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      imm_u:   dec.imm = {{32{inst[31]}}, inst[31:12], 12'b0};
      imm_j:   dec.imm = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: dec.imm = '0;  // r-type
    endcase
  end

  // ****************************
  // control
  // ****************************
  always_comb begin
    if (sub)                        dec.alu_op = alu_sub;
    else if (slti | slt | blt)      dec.alu_op = alu_lt;
    else if (sltiu | sltu | bltu)   dec.alu_op = alu_ltu;
    else if (andi | and_inst)       dec.alu_op = alu_and;
    else if (ori | or_inst)         dec.alu_op = alu_or;
    else if (xori | xor_inst)       dec.alu_op = alu_xor;
    else if (slli | sll)            dec.alu_op = alu_sll;
    else if (srli | srl)            dec.alu_op = alu_srl;
    else if (srai | sra)            dec.alu_op = alu_sra;
    else if (opc_lui)               dec.alu_op = alu_pass_imm;
    else if (beq)                   dec.alu_op = alu_eq;
    else if (bne)                   dec.alu_op = alu_ne;
    else if (bge)                   dec.alu_op = alu_ge;
    else if (bgeu)                  dec.alu_op = alu_geu;
    else if (addiw)                 dec.alu_op = alu_addw;
    else if (slliw | sllw)          dec.alu_op = alu_sllw;
    else if (srliw | srlw)          dec.alu_op = alu_srlw;
    else if (sraiw | sraw)          dec.alu_op = alu_sraw;
    else                            dec.alu_op = alu_add;  // addr, auipc, jumps
  end

  always_comb begin
    if (lb | lbu | sb)      dec.mem_width = width_b;
    else if (lh | lhu | sh) dec.mem_width = width_h;
    else if (lw | lwu | sw) dec.mem_width = width_w;
    else                    dec.mem_width = width_d;
  end

  assign dec.rd  = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

  assign dec.need_imm = fmt_i | fmt_s | fmt_u | fmt_j;
  assign dec.reg_wen  = alu_imm_grp | alu_reg_grp | word_grp | opc_lui | opc_auipc
                      | jal | jalr | load_grp;

  assign dec.is_auipc    = opc_auipc;
  assign dec.is_jal      = jal;
  assign dec.is_jalr     = jalr;
  assign dec.is_branch   = branch_grp;
  assign dec.is_load     = load_grp;
  assign dec.is_store    = store_grp;
  assign dec.is_ebreak   = ebreak;
  assign dec.is_unsigned = lbu | lhu | lwu;

  assign dec.illegal = ~(alu_imm_grp | alu_reg_grp | word_grp | opc_lui | opc_auipc | jal
                       | jalr | branch_grp | load_grp | store_grp | ebreak);

endmodule

`default_nettype wire

//--- logic/lsu.sv
// ****************************
// store lane replication and byte mask, load extract and extend
// ****************************
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_pkg::*; (
  input  logic [xlen-1:0] addr,
  input  logic [xlen-1:0] store_data,
  input  width_e          width,
  input  logic            is_unsigned,
  input  logic [xlen-1:0] mem_rdata,
  output logic [xlen-1:0] wdata,
  output logic [7:0]      wmask,
  output logic [xlen-1:0] load_data
);

  logic [2:0]      offset;
  logic [xlen-1:0] shifted;

  assign offset  = addr[2:0];  // byte within the doubleword
  assign shifted = mem_rdata >> {offset, 3'b000};

  // ****************************
  // store side
  // ****************************
  always_comb begin
    case (width)
      width_b: begin
        wdata = {8{store_data[7:0]}};
        wmask = 8'h01 << offset;
      end
      width_h: begin
        wdata = {4{store_data[15:0]}};
        wmask = 8'h03 << {offset[2:1], 1'b0};
      end
      width_w: begin
        wdata = {2{store_data[31:0]}};
        wmask = 8'h0f << {offset[2], 2'b00};
      end
      default: begin
        wdata = store_data;
        wmask = 8'hff;
      end
    endcase
  end

  // load side, sign bit masked off for unsigned forms
  always_comb begin
    case (width)
      width_b: load_data = {{56{shifted[7] & ~is_unsigned}}, shifted[7:0]};
      width_h: load_data = {{48{shifted[15] & ~is_unsigned}}, shifted[15:0]};
      width_w: load_data = {{32{shifted[31] & ~is_unsigned}}, shifted[31:0]};
      default: load_data = shifted;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/regfile.sv
// ****************************
// 32 x 64 integer registers, 2 async reads, 1 write at clk
// ****************************
`timescale 1ns/1ps
`default_nettype none

module regfile import rv_pkg::*; (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [reg_id_w-1:0] rs1,
  input  logic [reg_id_w-1:0] rs2,
  input  logic [reg_id_w-1:0] rd,
  input  logic                wen,
  input  logic [xlen-1:0]     wdata,
  output logic [xlen-1:0]     rdata1,
  output logic [xlen-1:0]     rdata2
);

  logic [xlen-1:0] regs [32];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && rd != '0) begin  // x0 stays zero
      regs[rd] <= wdata;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

  wdata_known_a: assert property (@(posedge clk) disable iff (!arst_n)
    wen |-> !$isunknown(wdata));

endmodule

`default_nettype wire

//--- logic/rv64_core.sv
// ****************************
// single-cycle rv64i core top, one instruction retires per clk
// instruction and data memories sit outside, read combinationally
// ****************************
`timescale 1ns/1ps
`default_nettype none

module rv64_core import rv_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [inst_w-1:0] inst,
  output logic [xlen-1:0]   pc,
  output logic [xlen-1:0]   mem_addr,
  output logic [xlen-1:0]   mem_wdata,
  output logic [7:0]        mem_wmask,
  output logic              mem_wen,
  input  logic [xlen-1:0]   mem_rdata,
  output logic              halted,
  output logic              illegal
);

  dec_if dec_bus ();

  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] alu_a;
  logic [xlen-1:0] alu_b;
  logic [xlen-1:0] alu_res;
  logic            taken;
  logic [xlen-1:0] load_data;
  logic [xlen-1:0] wb_data;
  logic [xlen-1:0] pc_plus4;
  logic [xlen-1:0] next_pc;
  logic            stop;    // ebreak or illegal in this cycle
  logic            retire;  // instruction commits at next edge

  decoder decoder_inst (
    .inst (inst),
    .dec  (dec_bus.dec)
  );

  assign stop   = dec_bus.is_ebreak | dec_bus.illegal;
  assign retire = ~halted & ~stop;

  regfile regfile_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .rs1    (dec_bus.rs1),
    .rs2    (dec_bus.rs2),
    .rd     (dec_bus.rd),
    .wen    (dec_bus.reg_wen & retire),
    .wdata  (wb_data),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  // ****************************
  // execute and memory
  // ****************************
  assign alu_a = (dec_bus.is_auipc | dec_bus.is_jal) ? pc : rs1_data;
  assign alu_b = dec_bus.need_imm ? dec_bus.imm : rs2_data;

  alu alu_inst (
    .op     (dec_bus.alu_op),
    .a      (alu_a),
    .b      (alu_b),
    .result (alu_res),
    .taken  (taken)
  );

  lsu lsu_inst (
    .addr        (alu_res),
    .store_data  (rs2_data),
    .width       (dec_bus.mem_width),
    .is_unsigned (dec_bus.is_unsigned),
    .mem_rdata   (mem_rdata),
    .wdata       (mem_wdata),
    .wmask       (mem_wmask),
    .load_data   (load_data)
  );

  assign mem_addr = alu_res;
  assign mem_wen  = dec_bus.is_store & retire;  // off while halted

  assign pc_plus4 = pc + 64'd4;
  assign wb_data  = dec_bus.is_load                    ? load_data :
                    (dec_bus.is_jal | dec_bus.is_jalr) ? pc_plus4  : alu_res;

  always_comb begin
    if ((dec_bus.is_branch & taken) | dec_bus.is_jal) next_pc = pc + dec_bus.imm;
    else if (dec_bus.is_jalr)                         next_pc = {alu_res[xlen-1:1], 1'b0};
    else                                              next_pc = pc_plus4;
  end

  // pc and sticky halt
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc      <= reset_pc;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else if (!halted) begin
      if (stop) begin
        halted  <= 1'b1;  // pc freezes on the halting instruction
        illegal <= dec_bus.illegal;
      end else begin
        pc <= next_pc;
      end
    end
  end

  pc_aligned_a: assert property (@(posedge clk) disable iff (!arst_n)
    pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/rv_pkg.sv
// ****************************
// shared widths, opcodes and control encodings for the rv64 core
// imported by every rtl file that needs them
// ****************************
`default_nettype none

package rv_pkg;

  // ****************************
  // widths
  // ****************************
  localparam int xlen     = 64;
  localparam int inst_w   = 32;
  localparam int reg_id_w = 5;

  localparam logic [xlen-1:0] reset_pc = '0;  // first fetch address

  // ****************************
  // major opcodes, inst[6:0]
  // ****************************
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_imm_32 = 7'b0011011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_32     = 7'b0111011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_system = 7'b1110011;

  // one encoded alu operation per instruction
  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_lt,
    alu_ltu,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_pass_imm,  // lui
    alu_eq,
    alu_ne,
    alu_ge,
    alu_geu,
    alu_addw,
    alu_sllw,
    alu_srlw,
    alu_sraw
  } alu_op_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    width_b = 2'd0,
    width_h = 2'd1,
    width_w = 2'd2,
    width_d = 2'd3
  } width_e;

  typedef enum logic [2:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_u,
    imm_j,
    imm_none
  } imm_fmt_e;

endpackage

`default_nettype wire

//--- test/tb_clkgen.sv
// ******************************
// testbench clock and power-on reset
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter realtime period = 20ns,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk    = 1'b0;
    arst_n = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;  // released on a falling edge
  end

endmodule

`default_nettype wire

//--- test/tb_rv64_core.sv
// ******************************
// testbench for the rv64 core, models both memories
// runs hand-assembled programs and checks memory and ports
// ******************************
`timescale 1ns/1ps
`default_nettype none

module tb_rv64_core import rv_pkg::*; ();

  logic            clk;
  logic            gen_arst_n;
  logic            tb_rst_n;
  logic [31:0]     inst;
  logic [63:0]     pc;
  logic [63:0]     mem_addr;
  logic [63:0]     mem_wdata;
  logic [7:0]      mem_wmask;
  logic            mem_wen;
  logic [63:0]     mem_rdata;
  logic            halted;
  logic            illegal;
  logic [31:0]     imem [256];
  logic [63:0]     dmem [256];
  logic [63:0]     exp_val [128];
  int              wp;
  int              slot;
  int              errors;
  int              write_count;

  tb_clkgen clkgen_inst (.clk(clk), .arst_n(gen_arst_n));

  rv64_core rv64_core_inst (
    .clk       (clk),
    .arst_n    (gen_arst_n & tb_rst_n),
    .inst      (inst),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wmask (mem_wmask),
    .mem_wen   (mem_wen),
    .mem_rdata (mem_rdata),
    .halted    (halted),
    .illegal   (illegal)
  );

  // ******************************
  // memory models
  // ******************************
  always @(negedge clk) begin
    inst = imem[pc[9:2]];
    #1 mem_rdata = dmem[mem_addr[10:3]];  // after the new inst settles
  end

  always @(posedge clk) begin
    if (mem_wen) begin
      write_count <= write_count + 1;
      for (int k = 0; k < 8; k++) begin
        if (mem_wmask[k]) dmem[mem_addr[10:3]][8*k +: 8] <= mem_wdata[8*k +: 8];
      end
    end
  end

  // ******************************
  // encoders and reference rules
  // ******************************
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, 5'd3, opc};  // x3 = x1 op x2
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [63:0] sx32(logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] sx12(logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  // load result from a doubleword, n bytes at byte offset off
  function automatic logic [63:0] pick(logic [63:0] d, int off, int n, bit uns);
    logic [63:0] v;
    v = d >> (8 * off);
    if (n < 8) begin
      v = v & ((64'd1 << (8 * n)) - 1);
      if (!uns && v[8*n-1]) v = v | ~((64'd1 << (8 * n)) - 1);
    end
    return v;
  endfunction

  function automatic logic [63:0] put(logic [63:0] old, logic [63:0] d, int off, int n);
    for (int k = 0; k < n; k++) old[8*(off+k) +: 8] = d[8*k +: 8];
    return old;
  endfunction

  function automatic bit br_taken(logic [2:0] f3, logic [63:0] a, logic [63:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // ******************************
  // helpers
  // ******************************
  task automatic check(logic [63:0] actual, logic [63:0] expected, string msg);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic emit(logic [31:0] w);
    imem[wp] = w;
    wp++;
  endtask

  task automatic store_slot(logic [4:0] rs, logic [63:0] expected);
    emit(enc_s(12'h400 + 12'(8 * slot), rs, 3'd3));
    exp_val[slot] = expected;
    slot++;
  endtask

  task automatic new_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = 32'h0010_0073;  // ebreak everywhere by default
      dmem[i] = {$urandom, $urandom};
    end
    wp   = 0;
    slot = 0;
  endtask

  task automatic run_program();
    int n;
    @(negedge clk);
    tb_rst_n = 1'b0;
    repeat (5) @(negedge clk);
    tb_rst_n    = 1'b1;
    write_count = 0;
    n = 0;
    while (!halted) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        $display("timeout: core did not halt within 200 cycles");
        $display("Verification failed");
        $finish;
      end
    end
  endtask

  task automatic check_slots(string name);
    for (int i = 0; i < slot; i++) begin
      check(dmem[128+i], exp_val[i], $sformatf("%s slot %0d", name, i));
    end
  endtask

  // ******************************
  // directed tests
  // ******************************
  task automatic test_reset();
    new_program();
    @(negedge clk);
    tb_rst_n = 1'b0;
    repeat (5) @(negedge clk);
    tb_rst_n = 1'b1;
    #2;
    check(pc, 64'd0, "reset pc");
    check(halted, 1'b0, "reset halted");
    check(illegal, 1'b0, "reset illegal");
    check(mem_wen, 1'b0, "reset mem_wen");
  endtask

  task automatic test_alu();
    logic [63:0] a;
    logic [63:0] b;
    new_program();
    a = dmem[0];
    b = dmem[1];
    emit(enc_i(12'd0, 5'd0, 3'd3, 5'd1, 7'h03));  // ld x1
    emit(enc_i(12'd8, 5'd0, 3'd3, 5'd2, 7'h03));  // ld x2
    emit(enc_r(7'h00, 3'd0, 7'h33)); store_slot(3, a + b);
    emit(enc_r(7'h20, 3'd0, 7'h33)); store_slot(3, a - b);
    emit(enc_r(7'h00, 3'd1, 7'h33)); store_slot(3, a << b[5:0]);
    emit(enc_r(7'h00, 3'd2, 7'h33)); store_slot(3, 64'($signed(a) < $signed(b)));
    emit(enc_r(7'h00, 3'd3, 7'h33)); store_slot(3, 64'(a < b));
    emit(enc_r(7'h00, 3'd4, 7'h33)); store_slot(3, a ^ b);
    emit(enc_r(7'h00, 3'd5, 7'h33)); store_slot(3, a >> b[5:0]);
    emit(enc_r(7'h20, 3'd5, 7'h33)); store_slot(3, 64'($signed(a) >>> b[5:0]));
    emit(enc_r(7'h00, 3'd6, 7'h33)); store_slot(3, a | b);
    emit(enc_r(7'h00, 3'd7, 7'h33)); store_slot(3, a & b);
    emit(enc_i(12'hffb, 1, 3'd0, 3, 7'h13)); store_slot(3, a + sx12(12'hffb));
    emit(enc_i(12'd100, 1, 3'd2, 3, 7'h13)); store_slot(3, 64'($signed(a) < 100));
    emit(enc_i(12'hfff, 1, 3'd3, 3, 7'h13)); store_slot(3, 64'(a < {64{1'b1}}));
    emit(enc_i(12'hfff, 1, 3'd4, 3, 7'h13)); store_slot(3, ~a);
    emit(enc_i(12'h0f0, 1, 3'd6, 3, 7'h13)); store_slot(3, a | 64'h0f0);
    emit(enc_i(12'h7ff, 1, 3'd7, 3, 7'h13)); store_slot(3, a & 64'h7ff);
    emit(enc_i(12'd13, 1, 3'd1, 3, 7'h13));  store_slot(3, a << 13);
    emit(enc_i(12'd45, 1, 3'd5, 3, 7'h13));  store_slot(3, a >> 45);
    emit(enc_i(12'h421, 1, 3'd5, 3, 7'h13)); store_slot(3, 64'($signed(a) >>> 33));
    // word forms
    emit(enc_i(12'd1234, 1, 3'd0, 3, 7'h1b)); store_slot(3, sx32(a[31:0] + 32'd1234));
    emit(enc_i(12'd7, 1, 3'd1, 3, 7'h1b));    store_slot(3, sx32(a[31:0] << 7));
    emit(enc_i(12'd9, 1, 3'd5, 3, 7'h1b));    store_slot(3, sx32(a[31:0] >> 9));
    emit(enc_i(12'h403, 1, 3'd5, 3, 7'h1b));
    store_slot(3, sx32(32'($signed(a[31:0]) >>> 3)));
    emit(enc_r(7'h00, 3'd1, 7'h3b)); store_slot(3, sx32(a[31:0] << b[4:0]));
    emit(enc_r(7'h00, 3'd5, 7'h3b)); store_slot(3, sx32(a[31:0] >> b[4:0]));
    emit(enc_r(7'h20, 3'd5, 7'h3b));
    store_slot(3, sx32(32'($signed(a[31:0]) >>> b[4:0])));
    emit({20'h8_1234, 5'd3, 7'h37}); store_slot(3, sx32({20'h8_1234, 12'h0}));
    emit({20'h0_0042, 5'd3, 7'h17});
    store_slot(3, 64'((wp - 1) * 4) + sx32({20'h0_0042, 12'h0}));
    run_program();
    check_slots("alu");
  endtask

  task automatic test_load_store();
    logic [63:0] d;
    logic [63:0] old [4];
    new_program();
    d = dmem[0];
    for (int i = 0; i < 4; i++) old[i] = dmem[64+i];
    for (int o = 0; o < 8; o++) begin
      emit(enc_i(12'(o), 0, 3'd0, 3, 7'h03)); store_slot(3, pick(d, o, 1, 0));
      emit(enc_i(12'(o), 0, 3'd4, 3, 7'h03)); store_slot(3, pick(d, o, 1, 1));
      if (o % 2 == 0) begin
        emit(enc_i(12'(o), 0, 3'd1, 3, 7'h03)); store_slot(3, pick(d, o, 2, 0));
        emit(enc_i(12'(o), 0, 3'd5, 3, 7'h03)); store_slot(3, pick(d, o, 2, 1));
      end
      if (o % 4 == 0) begin
        emit(enc_i(12'(o), 0, 3'd2, 3, 7'h03)); store_slot(3, pick(d, o, 4, 0));
        emit(enc_i(12'(o), 0, 3'd6, 3, 7'h03)); store_slot(3, pick(d, o, 4, 1));
      end
    end
    emit(enc_i(12'd0, 0, 3'd3, 1, 7'h03));  // ld x1, store source
    emit(enc_s(12'h203, 1, 3'd0));
    emit(enc_s(12'h20e, 1, 3'd1));
    emit(enc_s(12'h214, 1, 3'd2));
    emit(enc_s(12'h218, 1, 3'd3));
    run_program();
    check_slots("load");
    check(dmem[64], put(old[0], d, 3, 1), "sb neighbours");
    check(dmem[65], put(old[1], d, 6, 2), "sh neighbours");
    check(dmem[66], put(old[2], d, 4, 4), "sw neighbours");
    check(dmem[67], d, "sd");
  endtask

  task automatic test_control();
    logic [63:0] q;
    logic [2:0]  f3s [6];
    new_program();
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    emit(enc_i(12'd5, 0, 3'd0, 1, 7'h13));    // x1 = 5
    emit(enc_i(12'hffd, 0, 3'd0, 2, 7'h13));  // x2 = -3
    foreach (f3s[i]) begin
      for (int p = 0; p < 3; p++) begin
        emit(enc_i(12'd1, 0, 3'd0, 3, 7'h13));  // marker for taken
        emit(enc_b(13'd8, p == 1 ? 5'd2 : 5'd1, p == 0 ? 5'd2 : 5'd1, f3s[i]));
        emit(enc_i(12'd2, 0, 3'd0, 3, 7'h13));
        store_slot(3, br_taken(f3s[i], p == 1 ? -64'sd3 : 64'd5,
                               p == 0 ? -64'sd3 : 64'd5) ? 64'd1 : 64'd2);
      end
    end
    q = 64'(wp * 4);
    emit(enc_j(21'd8, 5'd5));                 // jal x5, +8
    emit(enc_i(12'd9, 0, 3'd0, 7, 7'h13));    // skipped
    store_slot(5, q + 4);
    q = 64'(wp * 4);
    emit({20'h0, 5'd8, 7'h17});               // auipc x8, 0
    emit(enc_i(12'd13, 8, 3'd0, 9, 7'h67));   // jalr x9, 13(x8), bit 0 cleared
    emit(enc_i(12'd7, 0, 3'd0, 7, 7'h13));    // skipped
    store_slot(9, q + 8);
    store_slot(7, 64'd0);
    run_program();
    check_slots("control");
    check(pc, 64'(wp * 4), "control halt pc");  // odd jalr target would shift this
  endtask

  task automatic test_ebreak();
    new_program();
    emit(enc_i(12'd1, 0, 3'd0, 1, 7'h13));
    emit(32'h0010_0073);
    store_slot(1, 64'd0);
    run_program();
    check(illegal, 1'b0, "ebreak illegal");
    repeat (10) begin
      @(negedge clk);
      check(pc, 64'd4, "ebreak pc hold");
      check(halted, 1'b1, "ebreak halted hold");
    end
    check(64'(write_count), 64'd0, "ebreak memory writes");
  endtask

  task automatic test_illegal(logic [31:0] bad, string name);
    logic [63:0] old;
    new_program();
    old = dmem[128];
    emit(enc_i(12'h55, 0, 3'd0, 1, 7'h13));
    emit(bad);
    store_slot(1, 64'h55);  // must never run
    run_program();
    check(illegal, 1'b1, {name, " illegal"});
    check(pc, 64'd4, {name, " pc"});
    check(dmem[128], old, {name, " store after halt"});
  endtask

  initial begin
    void'($urandom(32'ha6d6_cae1));
    tb_rst_n    = 1'b1;
    inst        = '0;
    mem_rdata   = '0;
    errors      = 0;
    write_count = 0;
    wait (gen_arst_n);
    test_reset();
    test_alu();
    test_load_store();
    test_control();
    test_ebreak();
    test_illegal(32'h0000_0073, "ecall");
    test_illegal(enc_r(7'h00, 3'd0, 7'h3b), "addw");
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
